// File: arm.sv
`timescale 1ns/1ps

module arm #(
  parameter logic [31:0] resetAddr = 32'h0
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] instruction,
  input  logic [31:0] readData,
  output logic [31:0] pc,
  output logic [31:0] aluResult,
  output logic [31:0] writeData,
  output logic        writeEnable
);

  armPkg::instrWord_t       instr;
  logic                     instrValid;
  logic [31:0]              pcPlus8;
  armPkg::decodeExecute_t   deReg;
  armPkg::executeMemory_t   emReg;
  armPkg::memoryWriteback_t mwReg;
  logic                     branchTaken;
  logic [31:0]              branchTarget;
  logic [31:0]              result;
  logic                     wbWrite;

  fetch #(.resetAddr(resetAddr)) u_fetch (
    .clk          (clk),
    .reset        (reset),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .pc           (pc),
    .instruction  (instruction),
    .instr        (instr),
    .instrValid   (instrValid),
    .pcPlus8      (pcPlus8)
  );

  // Taken branch also squashes the instruction in decode
  decode u_decode (
    .clk        (clk),
    .reset      (reset),
    .instr      (instr),
    .instrValid (instrValid),
    .pcPlus8    (pcPlus8),
    .flush      (branchTaken),
    .wbWrite    (wbWrite),
    .wbReg      (mwReg.rd),
    .wbData     (result),
    .deReg      (deReg)
  );

  execute u_execute (
    .clk          (clk),
    .reset        (reset),
    .deReg        (deReg),
    .emReg        (emReg),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget)
  );

  memory u_memory (
    .clk         (clk),
    .reset       (reset),
    .emReg       (emReg),
    .aluResult   (aluResult),
    .writeData   (writeData),
    .writeEnable (writeEnable),
    .readData    (readData),
    .mwReg       (mwReg)
  );

  // Writeback
  assign result  = mwReg.memToReg ? mwReg.readData : mwReg.aluResult;
  assign wbWrite = mwReg.valid && mwReg.regWrite;

endmodule

// File: armPkg.sv
package armPkg;

  // Major instruction class in bits 27:26
  typedef enum logic [1:0] {
    opData   = 2'b00,
    opMemory = 2'b01,
    opBranch = 2'b10
  } instrOp_t;

  // Data-processing opcodes that the core implements
  typedef enum logic [3:0] {
    dpAnd = 4'b0000,
    dpSub = 4'b0010,
    dpAdd = 4'b0100,
    dpCmp = 4'b1010,
    dpOrr = 4'b1100,
    dpMov = 4'b1101
  } dpOpcode_t;

  typedef enum logic [1:0] {
    aluAdd = 2'b00,
    aluSub = 2'b01,
    aluAnd = 2'b10,
    aluOrr = 2'b11
  } aluOp_t;

  typedef enum logic [3:0] {
    condEq = 4'h0,
    condNe = 4'h1,
    condCs = 4'h2,
    condCc = 4'h3,
    condMi = 4'h4,
    condPl = 4'h5,
    condVs = 4'h6,
    condVc = 4'h7,
    condHi = 4'h8,
    condLs = 4'h9,
    condGe = 4'hA,
    condLt = 4'hB,
    condGt = 4'hC,
    condLe = 4'hD,
    condAl = 4'hE
  } cond_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    cond_t       cond;
    instrOp_t    op;
    logic        i;
    logic [3:0]  opcode;
    logic        s;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dpInstr_t;

  typedef struct packed {
    cond_t       cond;
    instrOp_t    op;
    logic        i;
    logic        p;
    logic        u;
    logic        b;
    logic        w;
    logic        l;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] imm12;
  } memInstr_t;

  // Bit 25 is always set for B
  typedef struct packed {
    cond_t       cond;
    instrOp_t    op;
    logic        rsvd;
    logic        link;
    logic [23:0] imm24;
  } brInstr_t;

  // Same fetched word, viewed by instruction class
  typedef union packed {
    dpInstr_t  dp;
    memInstr_t mem;
    brInstr_t  br;
  } instrWord_t;

  typedef struct packed {
    logic   regWrite;
    logic   memWrite;
    logic   memToReg;
    logic   branch;
    logic   aluSrc;
    logic   flagWrite;
    aluOp_t aluOp;
    cond_t  cond;
  } ctrl_t;

  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] storeData;
    logic [31:0] imm;
    logic [31:0] pcPlus8;
    logic [3:0]  rd;
  } decodeExecute_t;

  typedef struct packed {
    logic        valid;
    logic        regWrite;
    logic        memWrite;
    logic        memToReg;
    logic [31:0] aluResult;
    logic [31:0] writeData;
    logic [3:0]  rd;
  } executeMemory_t;

  typedef struct packed {
    logic        valid;
    logic        regWrite;
    logic        memToReg;
    logic [31:0] aluResult;
    logic [31:0] readData;
    logic [3:0]  rd;
  } memoryWriteback_t;

endpackage

// File: armTb.sv
`timescale 1ns/1ps

module armTb;

  localparam int memWords  = 256;
  localparam int maxChecks = 64;

  logic        clk;
  logic        reset;
  logic [31:0] instruction;
  logic [31:0] readData;
  logic [31:0] pc;
  logic [31:0] aluResult;
  logic [31:0] writeData;
  logic        writeEnable;

  logic [31:0] instrRom [0:memWords-1];
  logic [31:0] dataRam  [0:memWords-1];

  // Expected stores in program order, then expected final RAM words
  logic [31:0] storeAddr [0:maxChecks-1];
  logic [31:0] storeData [0:maxChecks-1];
  logic [95:0] storeName [0:maxChecks-1];
  logic [31:0] finalAddr [0:maxChecks-1];
  logic [31:0] finalData [0:maxChecks-1];
  logic [95:0] finalName [0:maxChecks-1];

  int          numStores;
  int          numFinals;
  int          programLength;
  int          storeIdx;
  logic [31:0] endAddr;

  arm #(.resetAddr(32'h0)) i_dut (
    .clk         (clk),
    .reset       (reset),
    .instruction (instruction),
    .readData    (readData),
    .pc          (pc),
    .aluResult   (aluResult),
    .writeData   (writeData),
    .writeEnable (writeEnable)
  );

  bind arm arm_properties u_properties (
    .clk         (clk),
    .reset       (reset),
    .pc          (pc),
    .writeEnable (writeEnable),
    .branchTaken (branchTaken)
  );

  // Both memories answer within the same cycle
  assign instruction = instrRom[pc[9:2]];
  assign readData    = dataRam[aluResult[9:2]];

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic loadGolden();
    int          fd;
    int          count;
    string       line;
    logic [7:0]  tag;
    logic [7:0]  idx;
    logic [31:0] addr;
    logic [31:0] value;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    logic [95:0] name;
    fd = $fopen("arm_golden.txt", "r");
    if (fd == 0) begin
      stopOnError("Could not open arm_golden.txt for reading");
    end
    while (!$feof(fd)) begin
      line  = "";
      tag   = 8'h00;
      count = $fgets(line, fd);
      count = $sscanf(line, "%s", tag);
      if (tag == "P") begin
        count = $sscanf(line, "%s %h %h %h %h %h", tag, addr, w0, w1, w2, w3);
        if (count != 6) begin
          stopOnError("A program line in arm_golden.txt does not hold four words");
        end
        idx                   = addr[9:2];
        instrRom[idx]         = w0;
        instrRom[idx + 8'd1]  = w1;
        instrRom[idx + 8'd2]  = w2;
        instrRom[idx + 8'd3]  = w3;
        programLength         = programLength + 4;
        // Last program word is the terminal self-loop
        if (addr + 32'd12 > endAddr) endAddr = addr + 32'd12;
      end else if (tag == "S" || tag == "M") begin
        count = $sscanf(line, "%s %h %h %s", tag, addr, value, name);
        if (numStores >= maxChecks || numFinals >= maxChecks) begin
          stopOnError("arm_golden.txt holds more check lines than the testbench can keep");
        end
        if (tag == "S") begin
          storeAddr[numStores[5:0]] = addr;
          storeData[numStores[5:0]] = value;
          storeName[numStores[5:0]] = name;
          numStores = numStores + 1;
        end else begin
          finalAddr[numFinals[5:0]] = addr;
          finalData[numFinals[5:0]] = value;
          finalName[numFinals[5:0]] = name;
          numFinals = numFinals + 1;
        end
      end
    end
    $fclose(fd);
  endtask

  // Data RAM model and store trace check
  always @(posedge clk) begin
    if (reset) begin
      storeIdx <= 0;
      for (int k = 0; k < memWords; k++) begin
        dataRam[k[7:0]] <= {24'h5a_0000, k[7:0]};
      end
    end else if (writeEnable) begin
      assert (storeIdx < numStores)
        else stopOnError($sformatf("Store of %h to address %h came after the last expected store",
                                   writeData, aluResult));
      assert (aluResult == storeAddr[storeIdx[5:0]])
        else stopOnError($sformatf("FAIL %0s address expected %h actual %h",
                                   storeName[storeIdx[5:0]], storeAddr[storeIdx[5:0]], aluResult));
      assert (writeData == storeData[storeIdx[5:0]])
        else stopOnError($sformatf("FAIL %0s data expected %h actual %h",
                                   storeName[storeIdx[5:0]], storeData[storeIdx[5:0]], writeData));
      dataRam[aluResult[9:2]] <= writeData;
      storeIdx <= storeIdx + 1;
    end
  end

  initial begin
    int cycleCount;
    int cycleLimit;
    int endVisits;
    reset         = 1'b1;
    numStores     = 0;
    numFinals     = 0;
    programLength = 0;
    endAddr       = 32'h0;
    // Unused ROM words carry condition 0xF and never execute
    for (int k = 0; k < memWords; k++) begin
      instrRom[k[7:0]] = {24'hf0_0000, k[7:0]};
    end
    loadGolden();
    cycleLimit = (programLength + 20) * 4;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    cycleCount = 0;
    endVisits  = 0;
    // Second fetch of the self-loop means all older stores are done
    while (endVisits < 2) begin
      @(posedge clk);
      cycleCount = cycleCount + 1;
      if (pc == endAddr) begin
        endVisits = endVisits + 1;
      end
      if (cycleCount > cycleLimit) begin
        stopOnError($sformatf("Timeout: the program did not reach its final loop within %0d cycles",
                              cycleLimit));
      end
    end
    assert (storeIdx == numStores)
      else stopOnError($sformatf("FAIL storeCount expected %0d actual %0d", numStores, storeIdx));
    for (int k = 0; k < numFinals; k++) begin
      assert (dataRam[finalAddr[k[5:0]][9:2]] == finalData[k[5:0]])
        else stopOnError($sformatf("FAIL %0s expected %h actual %h", finalName[k[5:0]],
                                   finalData[k[5:0]], dataRam[finalAddr[k[5:0]][9:2]]));
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: arm_golden.txt
# P address word word word word : program image, four words from that address
# S address data name : expected store in order ; M address data name : final data word
P 00000000 e3a0c080 e3a01037 e3a0201a e3a030f0
P 00000010 e58c1000 e0814002 e0415002 e0016003
P 00000020 e1827003 e58c4004 e58c5008 e58c600c
P 00000030 e58c7010 e1510002 058c1014 158c2018
P 00000040 c58c301c b58c1020 258c4024 458c5028
P 00000050 e1520001 b3a08055 c3a09066 458c602c
P 00000060 e58c8030 e58c9034 e3510037 058c7038
P 00000070 e59ca004 e1a00000 e1a00000 e58ca03c
P 00000080 ea000001 e58c1040 e58c2044 e1510002
P 00000090 0a000001 e58c3048 e3a0b003 e3a0a000
P 000000a0 e1a00000 e25bb001 e28aa005 1afffffc
P 000000b0 e1a00000 e58ca04c e58cb050 e28f9000
P 000000c0 e1a00000 e1a00000 e58c9054 eafffffe
S 00000080 00000037 mov
S 00000084 00000051 add
S 00000088 0000001d sub
S 0000008c 00000030 and
S 00000090 000000fa orr
S 00000098 0000001a strne
S 0000009c 000000f0 strgt
S 000000a4 00000051 strcs
S 000000ac 00000030 strmi
S 000000b0 00000055 movlt
S 000000b4 00000000 movgtSkip
S 000000b8 000000fa streq
S 000000bc 00000051 ldr
S 000000c8 000000f0 beqNotTaken
S 000000cc 0000000f loopSum
S 000000d0 00000000 loopCount
S 000000d4 000000c4 pcRead
M 00000080 00000037 finalMov
M 00000094 5a000025 streqSkip
M 000000a0 5a000028 strltSkip
M 000000a8 5a00002a strmiSkip
M 000000bc 00000051 finalLdr
M 000000c0 5a000030 bSkipFirst
M 000000c4 5a000031 bSkipSecond
M 000000cc 0000000f finalLoop
M 000000d4 000000c4 finalPc

// File: arm_properties.sv
`timescale 1ns/1ps

module arm_properties (
  input logic        clk,
  input logic        reset,
  input logic [31:0] pc,
  input logic        writeEnable,
  input logic        branchTaken
);

  // No store once reset has been held for a full cycle
  property noStoreInReset;
    @(posedge clk) (reset && $past(reset)) |-> !writeEnable;
  endproperty

  property pcAligned;
    @(posedge clk) disable iff (reset) pc[1:0] == 2'b00;
  endproperty

  // Sequential fetch unless execute redirects or reset holds pc
  property pcStepsByFour;
    @(posedge clk) (!reset && !branchTaken) |=> pc == $past(pc) + 32'd4;
  endproperty

  assert property (noStoreInReset) else $error("writeEnable is high during reset");
  assert property (pcAligned) else $error("pc is not word aligned");
  assert property (pcStepsByFour) else $error("pc did not advance by 4 without a taken branch");

endmodule

// File: decode.sv
`timescale 1ns/1ps

module decode (
  input  logic                  clk,
  input  logic                  reset,
  input  armPkg::instrWord_t    instr,
  input  logic                  instrValid,
  input  logic [31:0]           pcPlus8,
  input  logic                  flush,
  input  logic                  wbWrite,
  input  logic [3:0]            wbReg,
  input  logic [31:0]           wbData,
  output armPkg::decodeExecute_t deReg
);

  armPkg::ctrl_t ctrl;
  logic [31:0]   imm;
  logic [3:0]    ra1;
  logic [3:0]    ra2;
  logic [31:0]   rfRd1;
  logic [31:0]   rfRd2;
  logic          movOp;

  registerFile u_registerFile (
    .clk   (clk),
    .reset (reset),
    .ra1   (ra1),
    .ra2   (ra2),
    .wa    (wbReg),
    .we    (wbWrite),
    .wd    (wbData),
    .r15   (pcPlus8),
    .rd1   (rfRd1),
    .rd2   (rfRd2)
  );

  always_comb begin
    ctrl      = '0;
    ctrl.cond = instr.dp.cond;
    imm       = '0;
    movOp     = 1'b0;
    ra1       = instr.dp.rn;
    ra2       = instr.dp.operand2[3:0];

    case (instr.dp.op)
      armPkg::opData: begin
        ctrl.aluSrc    = instr.dp.i;
        ctrl.flagWrite = instr.dp.s;
        ctrl.regWrite  = 1'b1;
        imm            = {24'b0, instr.dp.operand2[7:0]};
        case (instr.dp.opcode)
          armPkg::dpAdd: ctrl.aluOp = armPkg::aluAdd;
          armPkg::dpSub: ctrl.aluOp = armPkg::aluSub;
          armPkg::dpAnd: ctrl.aluOp = armPkg::aluAnd;
          armPkg::dpOrr: ctrl.aluOp = armPkg::aluOrr;
          armPkg::dpMov: begin
            // OR with a zero first operand
            ctrl.aluOp = armPkg::aluOrr;
            movOp      = 1'b1;
          end
          armPkg::dpCmp: begin
            ctrl.aluOp     = armPkg::aluSub;
            ctrl.regWrite  = 1'b0;
            ctrl.flagWrite = 1'b1;
          end
          default: begin
            ctrl.regWrite  = 1'b0;
            ctrl.flagWrite = 1'b0;
          end
        endcase
      end
      armPkg::opMemory: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = armPkg::aluAdd;
        ctrl.regWrite = instr.mem.l;
        ctrl.memToReg = instr.mem.l;
        ctrl.memWrite = !instr.mem.l;
        imm           = {20'b0, instr.mem.imm12};
        // Store data comes from the rd field
        ra2           = instr.mem.rd;
      end
      armPkg::opBranch: begin
        ctrl.branch = 1'b1;
        imm         = {{6{instr.br.imm24[23]}}, instr.br.imm24, 2'b00};
      end
      default: ;
    endcase
  end

  // Decode to execute register
  always_ff @(posedge clk) begin
    if (reset) begin
      deReg.valid <= 1'b0;
    end else begin
      deReg.valid <= instrValid && !flush;
    end
    deReg.ctrl      <= ctrl;
    deReg.rd1       <= movOp ? 32'b0 : rfRd1;
    deReg.rd2       <= rfRd2;
    deReg.storeData <= rfRd2;
    deReg.imm       <= imm;
    deReg.pcPlus8   <= pcPlus8;
    deReg.rd        <= instr.dp.rd;
  end

endmodule

// File: execute.sv
`timescale 1ns/1ps

module execute (
  input  logic                   clk,
  input  logic                   reset,
  input  armPkg::decodeExecute_t deReg,
  output armPkg::executeMemory_t emReg,
  output logic                   branchTaken,
  output logic [31:0]            branchTarget
);

  armPkg::flags_t flags;
  armPkg::flags_t aluFlags;
  logic           condPass;
  logic           issue;
  logic           subtract;
  logic [31:0]    srcA;
  logic [31:0]    srcB;
  logic [32:0]    sum;
  logic [31:0]    aluOut;

  // Condition check against the current flags
  always_comb begin
    case (deReg.ctrl.cond)
      armPkg::condEq: condPass = flags.z;
      armPkg::condNe: condPass = !flags.z;
      armPkg::condCs: condPass = flags.c;
      armPkg::condCc: condPass = !flags.c;
      armPkg::condMi: condPass = flags.n;
      armPkg::condPl: condPass = !flags.n;
      armPkg::condVs: condPass = flags.v;
      armPkg::condVc: condPass = !flags.v;
      armPkg::condHi: condPass = flags.c && !flags.z;
      armPkg::condLs: condPass = !flags.c || flags.z;
      armPkg::condGe: condPass = flags.n == flags.v;
      armPkg::condLt: condPass = flags.n != flags.v;
      armPkg::condGt: condPass = !flags.z && (flags.n == flags.v);
      armPkg::condLe: condPass = flags.z || (flags.n != flags.v);
      armPkg::condAl: condPass = 1'b1;
      default:        condPass = 1'b0;
    endcase
  end

  // Failed condition turns the slot into a bubble
  assign issue = deReg.valid && condPass;

  assign srcA     = deReg.rd1;
  assign srcB     = deReg.ctrl.aluSrc ? deReg.imm : deReg.rd2;
  assign subtract = deReg.ctrl.aluOp == armPkg::aluSub;
  // Subtract as A + ~B + 1, so carry is NOT borrow
  assign sum = {1'b0, srcA} + {1'b0, subtract ? ~srcB : srcB} + {32'b0, subtract};

  always_comb begin
    aluFlags = flags;
    case (deReg.ctrl.aluOp)
      armPkg::aluAnd: aluOut = srcA & srcB;
      armPkg::aluOrr: aluOut = srcA | srcB;
      default: begin
        aluOut     = sum[31:0];
        aluFlags.c = sum[32];
        if (subtract) begin
          aluFlags.v = (srcA[31] != srcB[31]) && (sum[31] != srcA[31]);
        end else begin
          aluFlags.v = (srcA[31] == srcB[31]) && (sum[31] != srcA[31]);
        end
      end
    endcase
    // Logic ops keep C and V
    aluFlags.n = aluOut[31];
    aluFlags.z = aluOut == 32'b0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (issue && deReg.ctrl.flagWrite) begin
      flags <= aluFlags;
    end
  end

  assign branchTaken  = issue && deReg.ctrl.branch;
  assign branchTarget = deReg.pcPlus8 + deReg.imm;

  // Execute to memory register
  always_ff @(posedge clk) begin
    if (reset) begin
      emReg.valid <= 1'b0;
    end else begin
      emReg.valid <= issue;
    end
    emReg.regWrite  <= deReg.ctrl.regWrite;
    emReg.memWrite  <= deReg.ctrl.memWrite;
    emReg.memToReg  <= deReg.ctrl.memToReg;
    emReg.aluResult <= aluOut;
    emReg.writeData <= deReg.storeData;
    emReg.rd        <= deReg.rd;
  end

endmodule

// File: fetch.sv
`timescale 1ns/1ps

module fetch #(
  parameter logic [31:0] resetAddr = 32'h0
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              branchTaken,
  input  logic [31:0]       branchTarget,
  output logic [31:0]       pc,
  input  logic [31:0]       instruction,
  output armPkg::instrWord_t instr,
  output logic              instrValid,
  output logic [31:0]       pcPlus8
);

  logic [31:0] nextPc;

  // Branch resolved in execute overrides sequential fetch
  assign nextPc = branchTaken ? branchTarget : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= resetAddr;
    end else begin
      pc <= nextPc;
    end
  end

  // Fetch to decode register
  always_ff @(posedge clk) begin
    if (reset) begin
      instrValid <= 1'b0;
    end else begin
      // Word fetched alongside a taken branch is squashed
      instrValid <= !branchTaken;
    end
    instr   <= armPkg::instrWord_t'(instruction);
    pcPlus8 <= pc + 32'd8;
  end

endmodule

// File: memory.sv
`timescale 1ns/1ps

module memory (
  input  logic                     clk,
  input  logic                     reset,
  input  armPkg::executeMemory_t   emReg,
  output logic [31:0]              aluResult,
  output logic [31:0]              writeData,
  output logic                     writeEnable,
  input  logic [31:0]              readData,
  output armPkg::memoryWriteback_t mwReg
);

  // Data port, address is the ALU result
  assign aluResult   = emReg.aluResult;
  assign writeData   = emReg.writeData;
  assign writeEnable = emReg.valid && emReg.memWrite;

  // Memory to writeback register
  always_ff @(posedge clk) begin
    if (reset) begin
      mwReg.valid <= 1'b0;
    end else begin
      mwReg.valid <= emReg.valid;
    end
    mwReg.regWrite  <= emReg.regWrite;
    mwReg.memToReg  <= emReg.memToReg;
    mwReg.aluResult <= emReg.aluResult;
    // Load data captured at the end of the memory cycle
    mwReg.readData  <= readData;
    mwReg.rd        <= emReg.rd;
  end

endmodule

// File: registerFile.sv
`timescale 1ns/1ps

module registerFile (
  input  logic        clk,
  input  logic        reset,
  input  logic [3:0]  ra1,
  input  logic [3:0]  ra2,
  input  logic [3:0]  wa,
  input  logic        we,
  input  logic [31:0] wd,
  input  logic [31:0] r15,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  // r0 to r14, the PC is not stored here
  logic [31:0] regs [0:14];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < 15; k++) begin
        regs[k] <= '0;
      end
    end else if (we && wa != 4'd15) begin
      regs[wa] <= wd;
    end
  end

  // Write-through so writeback and decode can share a cycle
  always_comb begin
    if (ra1 == 4'd15) rd1 = r15;
    else if (we && wa == ra1) rd1 = wd;
    else rd1 = regs[ra1];

    if (ra2 == 4'd15) rd2 = r15;
    else if (we && wa == ra2) rd2 = wd;
    else rd2 = regs[ra2];
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module armTb -f tb.f -o armSim \
  && ./obj_dir/armSim | tee sim.log
grep -qx "Simulation finished: PASS" sim.log \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }

// File: tb.f
armPkg.sv
registerFile.sv
fetch.sv
decode.sv
execute.sv
memory.sv
arm.sv
arm_properties.sv
armTb.sv
